/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it, the exit status carries the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
	--top-module tb_sprite_unit \
	-f sprite_unit.f \
	--Mdir obj_dir -o tb_sprite_unit \
	&& ./obj_dir/tb_sprite_unit \
	|| { echo "simulation build or run failed"; exit 1; }

/* sim/sprite_mem_model.sv */
`timescale 1ns/1ps

module sprite_mem_model (
	input  logic        clk,
	input  logic [20:0] spu_addr,
	input  logic        spu_req,
	output logic [15:0] spu_data,
	output logic        spu_strobe
);
	import sprite_pkg::*;

	logic [15:0] mem [4096];		// only the low 12 address bits decode
	logic        busy = 1'b0;		// word in flight
	logic [2:0]  wait_cnt = '0;
	logic        strobe_q = 1'b0;
	logic [15:0] data_q = '0;
	integer      seed = 60373;

	assign spu_strobe = strobe_q;
	assign spu_data   = data_q;

	// background pattern, every word differs
	initial
	begin
		pix_word_u w;
		for (int a = 0; a < 4096; a++)
		begin
			w.tc[0] = 8'(a * 29 + 3);
			w.tc[1] = 8'(a >> 4) ^ 8'(a * 7);	// upper address bits
			mem[a] = w;
		end
	end

	// --------------------------------------------------
	// request / strobe
	// --------------------------------------------------
	always @(posedge clk)
	begin
		if (strobe_q)
		begin
			strobe_q <= 1'b0;	// single pulse per word
			busy     <= 1'b0;
		end
		else if (busy)
		begin
			if (wait_cnt == 3'd0)
			begin
				strobe_q <= 1'b1;
				data_q   <= mem[spu_addr[11:0]];
			end
			else
				wait_cnt <= wait_cnt - 3'd1;
		end
		else if (spu_req)
		begin
			busy     <= 1'b1;
			wait_cnt <= 3'($random(seed) & 3);	// 1 to 4 cycles until the strobe
		end
	end

endmodule

/* sim/tb_sprite_unit.sv */
`timescale 1ns/1ps

module tb_sprite_unit;
	import sprite_pkg::*;

	// 19 lines of up to ~1.1k cycles, table loads on top, about 2x margin
	localparam int CYCLE_LIMIT = 40000;

	logic        clk = 1'b0;
	logic        line_start;
	logic [8:0]  vline;
	logic        cbeg;
	logic        post_cbeg;
	host_wr_t    host;
	logic [20:0] spu_addr;
	logic        spu_req;
	logic [15:0] spu_data;
	logic        spu_strobe;
	logic [5:0]  spixel;
	logic        spx_en;
	logic        line_busy;

	logic [7:0] attr [128];			// shadow of the host writes
	logic [7:0] pal [256];
	logic [6:0] ref_buf [2][512];	// expected {valid, colour}
	int         cycles = 0;
	integer     seed = 60373;
	string      test_name;
	int         lit;

	sprite_unit i_sprite_unit (.*);
	sprite_mem_model i_mem (.*);

	always #4 clk = ~clk;	// 8 ns

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
			stop_with_failure("timeout: the run went past its cycle limit");
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic compare_values(input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			stop_with_failure($sformatf("mismatch %s: expected %0h, actual %0h",
				test_name, exp, act));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;	// inputs move just after the edge
	endtask

	task automatic host_write(input logic sel, input logic [7:0] a, input logic [7:0] d);
		host.we   = 1'b1;
		host.sel  = sel;
		host.addr = a;
		host.data = d;
		next_cycle();
		host.we = 1'b0;
	endtask

	task automatic write_attr(input int s, input logic [2:0] r, input logic [7:0] d);
		host_write(1'b0, 8'(s * 8 + r), d);
		attr[s * 8 + r] = d;
	endtask

	task automatic set_sprite(input int s, input logic [8:0] x, input logic [8:0] y,
		input logic [6:0] wid, input logic [6:0] h, input cres_e mode,
		input logic [5:0] bank, input logic [20:0] adr, input logic fx, input logic fy);
		write_attr(s, R_XP, x[7:0]);
		write_attr(s, R_XS, {x[8], wid});
		write_attr(s, R_YP, y[7:0]);
		write_attr(s, R_YS, {y[8], h});
		write_attr(s, R_CR, {bank, mode});
		write_attr(s, R_AL, adr[7:0]);
		write_attr(s, R_AM, {fy, fx, adr[13:8]});
		write_attr(s, R_AH, {1'b0, adr[20:14]});
	endtask

	task automatic clear_sprites();
		for (int s = 0; s < NUM_SPRITES; s++)
			write_attr(s, R_CR, 8'h00);	// mode off
	endtask

	// entries with index bits 00 are transparent
	task automatic load_palette();
		logic [7:0] d;
		for (int a = 0; a < 256; a++)
		begin
			d = {1'b0, (a % 4 == 0), 6'(a * 37 + 5)};
			host_write(1'b1, 8'(a), d);
			pal[a] = d;
		end
	endtask

	// --------------------------------------------------
	// reference line buffer
	// --------------------------------------------------
	task automatic render_ref(input logic [8:0] v);
		logic [7:0]  cr;
		logic [7:0]  am;
		logic [7:0]  xs;
		logic [7:0]  ys;
		logic [9:0]  y0;
		logic [9:0]  yend;
		logic [8:0]  lofs;
		logic [8:0]  xp;
		logic [20:0] wa;
		logic [15:0] word;
		logic [7:0]  idx;
		logic [7:0]  col;
		int          base;
		int          ppw;
		int          bits;
		for (int s = 0; s < NUM_SPRITES; s++)
		begin
			base = s * 8;
			cr   = attr[base + R_CR];
			am   = attr[base + R_AM];
			xs   = attr[base + R_XS];
			ys   = attr[base + R_YS];
			y0   = {1'b0, ys[7], attr[base + R_YP]};
			yend = y0 + {1'b0, ys[6:0], 2'b00};
			if (cr[1:0] == 2'd0 || v < y0 || v >= yend)
				continue;	// off or not on this line
			lofs = am[7] ? 9'(yend - 10'd1 - v) : 9'(v - y0);
			ppw  = (cr[1:0] == 2'd3) ? 2 : ((cr[1:0] == 2'd2) ? 4 : 8);
			bits = 16 / ppw;
			wa   = {attr[base + R_AH][6:0], am[5:0], attr[base + R_AL]};
			wa   = wa + 21'(lofs) * 21'(xs[6:0]);
			xp   = {xs[7], attr[base + R_XP]};
			if (am[6])
				xp = 9'(xp + xs[6:0] * ppw - 1);	// right edge first
			for (int w = 0; w < xs[6:0]; w++)
			begin
				word = i_mem.mem[wa[11:0]];
				for (int p = 0; p < ppw; p++)
				begin
					idx = 8'((word >> (16 - bits * (p + 1))) & ((1 << bits) - 1));
					// index replaces the low bits of cr
					col = (ppw == 2) ? idx : pal[(cr & ~8'((1 << bits) - 1)) | idx];
					if (!col[6])
						ref_buf[v[0]][xp] = {1'b1, col[5:0]};
					xp = am[6] ? xp - 9'd1 : xp + 9'd1;
				end
				wa = wa + 21'd1;
			end
		end
	endtask

	// one pixel per cbeg, cleared on post_cbeg
	task automatic show_line(output int count);
		logic b;
		b = ~vline[0];
		count = 0;
		for (int i = 0; i < 512; i++)
		begin
			cbeg = 1'b1;
			next_cycle();
			cbeg      = 1'b0;
			post_cbeg = 1'b1;
			compare_values(ref_buf[b][i], {spx_en, spixel});
			if (spx_en)
				count++;	// pixels the display saw
			ref_buf[b][i] = '0;
			next_cycle();
			post_cbeg = 1'b0;
		end
	endtask

	task automatic run_line(input logic [8:0] v, input logic show, output int count);
		count      = 0;
		line_start = 1'b1;
		vline      = v;
		repeat (3) next_cycle();
		line_start = 1'b0;
		repeat (2) next_cycle();	// line_busy is up by now
		render_ref(v);
		if (show)
			show_line(count);
		while (line_busy)
			next_cycle();
		repeat (3) next_cycle();	// last writes through the palette stage
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic four_colour_test();
		pix_word_u w;
		test_name = "four_colour";
		clear_sprites();
		for (int r = 0; r < 16; r++)
		begin
			for (int i = 0; i < 8; i++)
				w.c4[i] = 2'(i + r);
			i_mem.mem[12'h100 + r] = w;
		end
		set_sprite(0, 9'd100, 9'd40, 7'd2, 7'd2, CRES_4C, 6'd5, 21'h100, 1'b0, 1'b0);
		run_line(9'd45, 1'b0, lit);
		run_line(9'd46, 1'b1, lit);
		compare_values(1, lit != 0);
	endtask

	task automatic mixed_modes_test();
		pix_word_u w;
		test_name = "mixed_modes";
		clear_sprites();
		for (int r = 0; r < 16; r++)
		begin
			for (int i = 0; i < 4; i++)
				w.c16[i] = 4'(r * 3 + i * 5);
			i_mem.mem[12'h200 + r] = w;
			for (int i = 0; i < 2; i++)
				w.tc[i] = {1'b0, 1'((r + i) % 3 == 0), 6'(r * 7 + i * 11)};	// some skipped
			i_mem.mem[12'h300 + r] = w;
		end
		set_sprite(2, 9'd20, 9'd100, 7'd3, 7'd1, CRES_16C, 6'd9, 21'h200, 1'b0, 1'b0);
		set_sprite(5, 9'd300, 9'd98, 7'd2, 7'd2, CRES_TC, 6'd0, 21'h300, 1'b0, 1'b0);
		run_line(9'd102, 1'b0, lit);
		run_line(9'd103, 1'b1, lit);
		compare_values(1, lit != 0);
	endtask

	task automatic flip_test();
		test_name = "flip";
		clear_sprites();
		set_sprite(1, 9'd200, 9'd60, 7'd2, 7'd1, CRES_4C, 6'd3, 21'h400, 1'b1, 1'b0);
		set_sprite(3, 9'd10, 9'd61, 7'd1, 7'd2, CRES_16C, 6'd12, 21'h500, 1'b1, 1'b1);
		set_sprite(7, 9'd400, 9'd58, 7'd3, 7'd1, CRES_TC, 6'd0, 21'h600, 1'b0, 1'b1);
		run_line(9'd62, 1'b0, lit);
		run_line(9'd63, 1'b1, lit);
		compare_values(1, lit != 0);
	endtask

	task automatic skip_overlap_test();
		pix_word_u w;
		test_name = "skip_overlap";
		clear_sprites();
		for (int r = 0; r < 8; r++)
		begin
			for (int i = 0; i < 2; i++)
				w.tc[i] = {2'b00, 6'(40 + r * 2 + i)};	// all opaque
			i_mem.mem[12'h840 + r] = w;
		end
		set_sprite(0, 9'd50, 9'd0, 7'd2, 7'd4, CRES_4C, 6'd1, 21'h800, 1'b0, 1'b0);
		set_sprite(4, 9'd60, 9'd0, 7'd2, 7'd4, CRES_OFF, 6'd2, 21'h810, 1'b0, 1'b0);
		set_sprite(6, 9'd100, 9'd20, 7'd1, 7'd2, CRES_16C, 6'd3, 21'h820, 1'b0, 1'b0);
		set_sprite(8, 9'd100, 9'd11, 7'd1, 7'd1, CRES_4C, 6'd4, 21'h828, 1'b0, 1'b0);
		set_sprite(9, 9'd100, 9'd6, 7'd1, 7'd1, CRES_TC, 6'd0, 21'h830, 1'b0, 1'b0);
		set_sprite(10, 9'd100, 9'd266, 7'd1, 7'd4, CRES_4C, 6'd6, 21'h838, 1'b0, 1'b0);
		set_sprite(12, 9'd54, 9'd8, 7'd2, 7'd1, CRES_TC, 6'd0, 21'h840, 1'b0, 1'b0);
		set_sprite(15, 9'd52, 9'd10, 7'd1, 7'd1, CRES_16C, 6'd7, 21'h850, 1'b0, 1'b0);
		run_line(9'd10, 1'b0, lit);
		run_line(9'd11, 1'b1, lit);
		compare_values(1, lit != 0);
	endtask

	// shown once, then shown again after an empty render
	task automatic clear_test();
		pix_word_u w;
		test_name = "clear_behind";
		clear_sprites();
		for (int r = 0; r < 16; r++)
		begin
			for (int i = 0; i < 8; i++)
				w.c4[i] = 2'(1 + (i + r) % 3);
			i_mem.mem[12'h900 + r] = w;
		end
		set_sprite(3, 9'd0, 9'd200, 7'd4, 7'd1, CRES_4C, 6'd11, 21'h900, 1'b0, 1'b0);
		run_line(9'd200, 1'b0, lit);
		run_line(9'd201, 1'b1, lit);
		compare_values(1, lit != 0);
		write_attr(3, R_CR, 8'h00);
		run_line(9'd202, 1'b0, lit);
		run_line(9'd203, 1'b1, lit);
		compare_values(0, lit);
	endtask

	task automatic random_test();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [8:0]  v;
		test_name = "random_mix";
		for (int round = 0; round < 3; round++)
		begin
			v = 9'(280 + round * 40);
			for (int s = 0; s < NUM_SPRITES; s++)
			begin
				r1 = $random(seed);
				r2 = $random(seed);
				set_sprite(s, r1[8:0], 9'(v - r1[12:9]), 7'(1 + r1[14:13]),
					7'(1 + r1[16:15]), cres_e'(r1[18:17]), r1[24:19], 21'(r2[11:0]),
					r1[25], r1[26]);
			end
			run_line(v, 1'b0, lit);
			run_line(v + 9'd1, 1'b1, lit);
		end
	endtask

	// --------------------------------------------------
	// main
	// --------------------------------------------------
	initial
	begin
		line_start = 1'b1;
		vline      = '0;
		cbeg       = 1'b0;
		post_cbeg  = 1'b0;
		host       = '0;
		for (int i = 0; i < 128; i++)
			attr[i] = '0;
		for (int i = 0; i < 512; i++)
		begin
			ref_buf[0][i] = '0;
			ref_buf[1][i] = '0;
		end
		test_name = "reset";
		run_line(9'd0, 1'b0, lit);	// empty line out of reset
		load_palette();
		four_colour_test();
		mixed_modes_test();
		flip_test();
		skip_overlap_test();
		clear_test();
		random_test();
		$display("sim passed");
		$finish;
	end

endmodule

/* sprite_unit.f */
src/sprite_pkg.sv
src/sprite_attr_file.sv
src/sprite_palette.sv
src/sprite_fetch.sv
src/line_buffer.sv
src/sprite_unit.sv
sim/sprite_mem_model.sv
sim/tb_sprite_unit.sv

/* src/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
	input  logic             clk,
	input  logic             line_start,
	input  logic             sel,		// render buffer
	input  sprite_pkg::slw_t slw,
	output logic [7:0]       pal_ra,
	input  logic [7:0]       pal_rd,
	input  logic             cbeg,
	input  logic             post_cbeg,
	output logic [5:0]       spixel,
	output logic             spx_en
);
	import sprite_pkg::*;

	slw_t slw_d;					// request aligned with pal_rd
	logic [7:0] colour;
	logic wr_en;
	logic [LINE_AW-1:0] rd_ptr;		// display pointer
	logic [6:0] rd_word [2];

	assign pal_ra = slw.value;	// tc bytes look up too, result ignored

	// --------------------------------------------------
	// render write path
	// --------------------------------------------------
	assign colour = slw_d.direct ? slw_d.value : pal_rd;
	assign wr_en  = slw_d.valid && !colour[6];	// bit 6 = transparent

	for (genvar b = 0; b < 2; b++)
	begin : g_buf
		logic [6:0] mem [1 << LINE_AW];	// {valid, colour}

		// buffers start out empty
		initial
		begin
			for (int i = 0; i < (1 << LINE_AW); i++)
				mem[i] = '0;
		end

		always_ff @(posedge clk)
		begin
			if (sel == 1'(b))
			begin
				if (wr_en)
					mem[slw_d.addr] <= {1'b1, colour[5:0]};
			end
			else if (post_cbeg)
				mem[rd_ptr] <= '0;	// clear behind display
		end

		assign rd_word[b] = mem[rd_ptr];
	end

	// --------------------------------------------------
	// display side
	// --------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			slw_d  <= '0;
			rd_ptr <= '0;
			spx_en <= 1'b0;
		end
		else
		begin
			slw_d <= slw;
			if (cbeg)
				spx_en <= rd_word[~sel][6];
			if (post_cbeg)
				rd_ptr <= rd_ptr + 1'b1;	// next pixel
		end
	end

	always_ff @(posedge clk)
	begin
		if (cbeg)
			spixel <= rd_word[~sel][5:0];
	end

	// clear must follow the read, never share its cycle
	a_strobe_order: assert property (@(posedge clk) disable iff (line_start)
		!(cbeg && post_cbeg));

endmodule

/* src/sprite_attr_file.sv */
`timescale 1ns/1ps

module sprite_attr_file (
	input  logic                         clk,
	input  sprite_pkg::host_wr_t         host,
	input  logic [sprite_pkg::ATTR_AW-1:0] ra,
	output logic [7:0]                   rd
);
	import sprite_pkg::*;

	logic [7:0] mem [1 << ATTR_AW];	// 16 sprites x 8 regs
	logic       host_we;

	assign host_we = host.we && !host.sel;

	// all sprites come up with mode off
	initial
	begin
		for (int i = 0; i < (1 << ATTR_AW); i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk)
	begin
		if (host_we)
			mem[host.addr[ATTR_AW-1:0]] <= host.data;	// host side
		rd <= mem[ra];	// fetch side, one cycle latency
	end

	// host software must stay inside the sprite table
	a_host_addr: assert property (@(posedge clk)
		host_we |-> (host.addr < 8'(1 << ATTR_AW)));

endmodule

/* src/sprite_fetch.sv */
`timescale 1ns/1ps

module sprite_fetch (
	input  logic                           clk,
	input  logic                           line_start,
	input  logic [8:0]                     vline,
	output logic [sprite_pkg::ATTR_AW-1:0] attr_ra,
	input  logic [7:0]                     attr_rd,
	output logic [20:0]                    spu_addr,
	output logic                           spu_req,
	input  logic [15:0]                    spu_data,
	input  logic                           spu_strobe,
	output sprite_pkg::slw_t               slw,
	output logic                           line_busy
);
	import sprite_pkg::*;

	// attr_rd in each state holds the register asked for two states back
	typedef enum logic [3:0] {
		S_START, S_CR, S_AM, S_YP, S_YS, S_VIS, S_XS,
		S_AL, S_AH, S_XP, S_FETCH, S_PIX, S_DONE
	} state_e;

	state_e state;
	logic [SPR_IDX_W-1:0] num;	// current sprite
	logic [2:0] sa;				// register index being read
	logic [6:0] wcnt;			// words left on this line

	cres_e      cres;
	logic [5:0] bank;			// palette bank
	logic       flipx, flipy;
	logic [7:0] yp_lo;
	logic [8:0] lofs;			// line inside the sprite
	logic       x8;
	logic [6:0] wid;			// width in words
	logic [20:0] adr_base;
	pix_word_u  wbuf;			// word being drawn
	logic [2:0] pcnt;			// pixel inside the word
	logic [8:0] xpos;			// line buffer address

	logic [8:0] ypc;
	logic [9:0] yend;
	logic       vis;
	logic [8:0] lofs_c;
	logic [9:0] pix_w;
	logic [8:0] xstart;
	logic [2:0] plast;
	logic       pix_last;
	logic       last_spr;
	logic       spr_end;

	assign attr_ra = {num, sa};

	// --------------------------------------------------
	// visibility and geometry
	// --------------------------------------------------
	assign ypc  = {attr_rd[7], yp_lo};	// valid in S_VIS
	assign yend = {1'b0, ypc} + {1'b0, attr_rd[6:0], 2'b00};
	assign vis  = (vline >= ypc) && ({1'b0, vline} < yend);
	assign lofs_c = flipy ? 9'(yend - 10'd1 - {1'b0, vline}) : (vline - ypc);

	always_comb
	begin
		case (cres)
			CRES_TC:  pix_w = {2'b00, wid, 1'b0};	// 2 px per word
			CRES_16C: pix_w = {1'b0, wid, 2'b00};	// 4 px
			default:  pix_w = {wid, 3'b000};		// 8 px
		endcase
	end

	// flipped sprites are drawn right to left
	assign xstart = flipx ? 9'({x8, attr_rd} + pix_w - 10'd1) : {x8, attr_rd};

	assign plast = (cres == CRES_4C) ? 3'd7 : ((cres == CRES_16C) ? 3'd3 : 3'd1);
	assign pix_last = (pcnt == plast);
	assign last_spr = (num == SPR_IDX_W'(NUM_SPRITES - 1));

	// off, invisible, or last pixel of last word
	assign spr_end = ((state == S_AM) && (cres_e'(attr_rd[1:0]) == CRES_OFF))
		|| ((state == S_VIS) && !vis)
		|| ((state == S_PIX) && pix_last && (wcnt == 7'd1));

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk or posedge line_start)
	begin
		if (line_start)
		begin
			state     <= S_START;
			num       <= '0;
			sa        <= R_CR;
			wcnt      <= '0;
			spu_req   <= 1'b0;
			line_busy <= 1'b0;
		end
		else
		begin
			case (state)
				S_START:
				begin
					line_busy <= 1'b1;
					state     <= S_CR;
				end
				S_CR:
				begin
					sa    <= R_AM;	// cr on the way
					state <= S_AM;
				end
				S_AM:
				begin
					sa    <= R_YP;
					state <= S_YP;
				end
				S_YP:
				begin
					sa    <= R_YS;
					state <= S_YS;
				end
				S_YS:
				begin
					sa    <= R_XS;
					state <= S_VIS;
				end
				S_VIS:
				begin
					sa    <= R_AL;
					state <= S_XS;
				end
				S_XS:
				begin
					sa    <= R_AH;
					state <= S_AL;
				end
				S_AL:
				begin
					sa    <= R_XP;
					state <= S_AH;
				end
				S_AH: state <= S_XP;
				S_XP:
				begin
					wcnt    <= wid;
					spu_req <= 1'b1;	// first word of the line
					state   <= S_FETCH;
				end
				S_FETCH:
				begin
					if (spu_strobe)
					begin
						spu_req <= 1'b0;
						state   <= S_PIX;
					end
				end
				S_PIX:
				begin
					if (pix_last && (wcnt != 7'd1))
					begin
						wcnt    <= wcnt - 7'd1;
						spu_req <= 1'b1;	// next word
						state   <= S_FETCH;
					end
				end
				S_DONE: state <= S_DONE;
				default: state <= S_DONE;
			endcase

			// sprite finished, move on
			if (spr_end)
			begin
				sa <= R_CR;
				if (last_spr)
				begin
					line_busy <= 1'b0;
					state     <= S_DONE;
				end
				else
				begin
					num   <= num + 1'b1;
					state <= S_CR;
				end
			end
		end
	end

	// --------------------------------------------------
	// datapath
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		case (state)
			S_AM:
			begin
				cres <= cres_e'(attr_rd[1:0]);
				bank <= attr_rd[7:2];
			end
			S_YP:
			begin
				adr_base[13:8] <= attr_rd[5:0];
				flipx <= attr_rd[6];
				flipy <= attr_rd[7];
			end
			S_YS: yp_lo <= attr_rd;
			S_VIS: lofs <= lofs_c;
			S_XS:
			begin
				x8  <= attr_rd[7];
				wid <= attr_rd[6:0];
			end
			S_AL: adr_base[7:0] <= attr_rd;
			S_AH: adr_base[20:14] <= attr_rd[6:0];
			S_XP:
			begin
				spu_addr <= adr_base + 21'(lofs) * 21'(wid);	// row start
				xpos     <= xstart;
			end
			S_FETCH:
			begin
				if (spu_strobe)
				begin
					wbuf <= spu_data;
					pcnt <= '0;
				end
			end
			S_PIX:
			begin
				pcnt <= pcnt + 3'd1;
				xpos <= flipx ? (xpos - 9'd1) : (xpos + 9'd1);
				if (pix_last)
					spu_addr <= spu_addr + 21'd1;
			end
			default: begin end
		endcase
	end

	// one write request per pixel
	always_comb
	begin
		slw        = '0;
		slw.valid  = (state == S_PIX);
		slw.direct = (cres == CRES_TC);
		slw.addr   = xpos;
		case (cres)
			CRES_4C:  slw.value = {bank, wbuf.c4[pcnt]};
			CRES_16C: slw.value = {bank[5:2], wbuf.c16[pcnt[1:0]]};	// index in low bits
			default:  slw.value = wbuf.tc[pcnt[0]];
		endcase
	end

	// one word in flight, memory must be idle when a request starts
	a_req_rise: assert property (@(posedge clk) disable iff (line_start)
		$rose(spu_req) |-> !spu_strobe);

	a_word_width: assert property (@(posedge clk) disable iff (line_start)
		$rose(spu_req) |-> (wcnt != '0));

endmodule

/* src/sprite_palette.sv */
`timescale 1ns/1ps

module sprite_palette (
	input  logic                 clk,
	input  sprite_pkg::host_wr_t host,
	input  logic [7:0]           ra,
	output logic [7:0]           rd
);

	// 64 banks of 4 entries
	// bit 6 = transparent, bits 5..0 = colour
	logic [7:0] mem [256];
	logic       host_we;

	assign host_we = host.we && host.sel;

	// host write port
	always_ff @(posedge clk)
	begin
		if (host_we)
			mem[host.addr] <= host.data;
	end

	// lookup for the line buffer, registered
	always_ff @(posedge clk)
	begin
		rd <= mem[ra];
	end

endmodule

/* src/sprite_pkg.sv */
package sprite_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	localparam int NUM_SPRITES = 16;	// sprites scanned per line
	localparam int SPR_IDX_W = 4;		// sprite number width
	localparam int ATTR_AW = 7;			// {sprite, reg index}
	localparam int LINE_AW = 9;			// 512 pixels per line buffer

	// attribute register index, low 3 bits of the attribute address
	localparam logic [2:0] R_XP = 3'd0;	// X[7:0]
	localparam logic [2:0] R_XS = 3'd1;	// X[8], width in words
	localparam logic [2:0] R_YP = 3'd2;	// Y[7:0]
	localparam logic [2:0] R_YS = 3'd3;	// Y[8], height / 4
	localparam logic [2:0] R_CR = 3'd4;	// palette bank, colour mode
	localparam logic [2:0] R_AL = 3'd5;	// ADR[7:0]
	localparam logic [2:0] R_AM = 3'd6;	// flips, ADR[13:8]
	localparam logic [2:0] R_AH = 3'd7;	// ADR[20:14]

	typedef enum logic [1:0] {
		CRES_OFF = 2'd0,
		CRES_4C  = 2'd1,
		CRES_16C = 2'd2,
		CRES_TC  = 2'd3
	} cres_e;

	// one memory word, pixel 0 always in the top field
	typedef union packed {
		logic [0:7][1:0] c4;	// 4-colour indices
		logic [0:3][3:0] c16;	// 16-colour indices
		logic [0:1][7:0] tc;	// true colour, bit 6 = transparent
	} pix_word_u;

	typedef struct packed {
		logic       we;
		logic       sel;	// 0 attributes, 1 palette
		logic [7:0] addr;
		logic [7:0] data;
	} host_wr_t;

	// render write request towards the line buffer
	typedef struct packed {
		logic               valid;
		logic               direct;	// value is a true-colour byte
		logic [LINE_AW-1:0] addr;
		logic [7:0]         value;	// palette address or tc byte
	} slw_t;

endpackage

/* src/sprite_unit.sv */
`timescale 1ns/1ps

module sprite_unit (
	input  logic                 clk,
	input  logic                 line_start,
	input  logic [8:0]           vline,
	input  logic                 cbeg,
	input  logic                 post_cbeg,
	input  sprite_pkg::host_wr_t host,
	output logic [20:0]          spu_addr,
	output logic                 spu_req,
	input  logic [15:0]          spu_data,
	input  logic                 spu_strobe,
	output logic [5:0]           spixel,
	output logic                 spx_en,
	output logic                 line_busy
);
	import sprite_pkg::*;

	logic [ATTR_AW-1:0] attr_ra;
	logic [7:0]         attr_rd;
	logic [7:0]         pal_ra;
	logic [7:0]         pal_rd;
	slw_t               slw;		// fetch to line buffer

	// --------------------------------------------------
	// host loaded tables
	// --------------------------------------------------
	sprite_attr_file i_attr (
		.clk  (clk),
		.host (host),
		.ra   (attr_ra),
		.rd   (attr_rd)
	);

	sprite_palette i_pal (
		.clk  (clk),
		.host (host),
		.ra   (pal_ra),
		.rd   (pal_rd)
	);

	// --------------------------------------------------
	// render and display
	// --------------------------------------------------
	sprite_fetch i_fetch (
		.clk        (clk),
		.line_start (line_start),
		.vline      (vline),
		.attr_ra    (attr_ra),
		.attr_rd    (attr_rd),
		.spu_addr   (spu_addr),
		.spu_req    (spu_req),
		.spu_data   (spu_data),
		.spu_strobe (spu_strobe),
		.slw        (slw),
		.line_busy  (line_busy)
	);

	line_buffer i_lbuf (
		.clk        (clk),
		.line_start (line_start),
		.sel        (vline[0]),	// odd lines render into buffer 1
		.slw        (slw),
		.pal_ra     (pal_ra),
		.pal_rd     (pal_rd),
		.cbeg       (cbeg),
		.post_cbeg  (post_cbeg),
		.spixel     (spixel),
		.spx_en     (spx_en)
	);

endmodule
